// ==== filelist.f ====
+incdir+logic
logic/a23_axi_pkg.sv
logic/a23_axi_read_engine.sv
logic/a23_axi_write_engine.sv
logic/a23_axi_resp_merge.sv
logic/a23_axi_if.sv
verification/a23_axi_slave_model.sv
verification/tb_a23_axi_if.sv

// ==== run.sh ====
#!/bin/sh
# build and run the a23 AXI bus interface testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
	--top-module tb_a23_axi_if -o sim_tb_a23_axi_if

# the log decides the result, so a failing run must not stop the script here
./obj_dir/sim_tb_a23_axi_if > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== verification/tb_a23_axi_if.sv ====
// testbench for the a23 AXI bus interface
// runs a table of core and cache requests against the AXI slave model
`timescale 1ns/100ps
`include "a23_axi_defs.svh"

module tb_a23_axi_if;
	import a23_axi_pkg::*;

	typedef enum logic [1:0] {
		OP_CORE_RD,
		OP_CORE_WR,
		OP_LINE_FILL,
		OP_WRITE_BACK
	} op_t;

	// one request and its expected outcome
	// fills expect four words in wrap order, core reads only the first
	typedef struct packed {
		op_t               op;
		logic [31:0]       addr;
		logic [31:0]       wdata;
		logic [3:0]        be;
		logic              excl;
		logic [0:3][31:0]  exp_data;
		logic              exp_abt;
	} entry_t;

	localparam int N_ENTRIES        = 12;
	localparam int CYCLES_PER_ENTRY = 40;

	// unwritten words hold their word address inverted
	entry_t tbl [N_ENTRIES] = '{
		// op           address        wdata          be    excl  expected data            abt
		'{OP_CORE_RD,   32'h0000_0040, 32'h0000_0000, 4'h0, 1'b0, '{32'hFFFF_FFEF, '0, '0, '0}, 1'b0},
		'{OP_CORE_WR,   32'h0000_0040, 32'h1234_5678, 4'h5, 1'b0, '{'0, '0, '0, '0}, 1'b0},
		// bytes 0 and 2 from the store, the rest preloaded
		'{OP_CORE_RD,   32'h0000_0040, 32'h0000_0000, 4'h0, 1'b0, '{32'hFF34_FF78, '0, '0, '0}, 1'b0},
		'{OP_LINE_FILL, 32'h0000_0108, 32'h0000_0000, 4'h0, 1'b0,
			'{32'hFFFF_FFBD, 32'hFFFF_FFBC, 32'hFFFF_FFBF, 32'hFFFF_FFBE}, 1'b0},
		'{OP_WRITE_BACK, 32'h0000_0200, 32'hCAFE_F00D, 4'hF, 1'b0, '{'0, '0, '0, '0}, 1'b0},
		'{OP_CORE_RD,   32'h0000_0200, 32'h0000_0000, 4'h0, 1'b0, '{32'hCAFE_F00D, '0, '0, '0}, 1'b0},
		// error region
		'{OP_CORE_RD,   32'h8000_0010, 32'h0000_0000, 4'h0, 1'b0, '{'0, '0, '0, '0}, 1'b1},
		'{OP_CORE_WR,   32'h8000_0020, 32'h5555_AAAA, 4'hF, 1'b0, '{'0, '0, '0, '0}, 1'b1},
		// exclusive pair
		'{OP_CORE_RD,   32'h0000_0300, 32'h0000_0000, 4'h0, 1'b1, '{32'hFFFF_FF3F, '0, '0, '0}, 1'b0},
		'{OP_CORE_WR,   32'h0000_0304, 32'hA5A5_5A5A, 4'hF, 1'b1, '{'0, '0, '0, '0}, 1'b0},
		'{OP_CORE_RD,   32'h0000_0304, 32'h0000_0000, 4'h0, 1'b0, '{32'hA5A5_5A5A, '0, '0, '0}, 1'b0},
		'{OP_LINE_FILL, 32'h0000_0300, 32'h0000_0000, 4'h0, 1'b0,
			'{32'hFFFF_FF3F, 32'hA5A5_5A5A, 32'hFFFF_FF3D, 32'hFFFF_FF3C}, 1'b0}
	};

	// core and cache side
	logic                    i_clk = 1'b0;
	logic                    i_rstn;
	logic                    i_select;
	logic                    i_write_enable;
	logic                    i_exclusive;
	logic                    i_cache_req;
	logic [`A23_ADDR_W-1:0]  i_address;
	logic [`A23_DATA_W-1:0]  i_write_data;
	logic [`A23_STRB_W-1:0]  i_byte_enable;
	logic                    o_ack, o_stall, o_dabt, o_stall_cache, o_cache_rvalid;
	logic [`A23_DATA_W-1:0]  o_read_data;
	// AXI between the DUT and the slave model
	logic                    o_arvalid, i_arready, o_arlock, o_rready, i_rvalid, i_rlast;
	logic [`A23_ADDR_W-1:0]  o_araddr;
	logic [7:0]              o_arlen;
	logic [1:0]              o_arburst;
	logic [2:0]              o_arsize;
	logic [`A23_DATA_W-1:0]  i_rdata;
	axi_resp_t               i_rresp;
	logic                    o_awvalid, i_awready, o_awlock, o_wvalid, i_wready, o_wlast;
	logic                    i_bvalid, o_bready;
	logic [`A23_ADDR_W-1:0]  o_awaddr;
	logic [7:0]              o_awlen;
	logic [2:0]              o_awsize;
	logic [`A23_DATA_W-1:0]  o_wdata;
	logic [`A23_STRB_W-1:0]  o_wstrb;
	axi_resp_t               i_bresp;

	a23_axi_if dut0 (.*);

	a23_axi_slave_model slave0 (
		.i_clk, .i_rstn,
		.i_arvalid(o_arvalid), .o_arready(i_arready), .i_araddr(o_araddr),
		.i_arburst(o_arburst), .i_arlen(o_arlen), .i_arlock(o_arlock),
		.o_rvalid(i_rvalid), .i_rready(o_rready), .o_rdata(i_rdata),
		.o_rresp(i_rresp), .o_rlast(i_rlast),
		.i_awvalid(o_awvalid), .o_awready(i_awready), .i_awaddr(o_awaddr),
		.i_awlock(o_awlock), .i_wvalid(o_wvalid), .o_wready(i_wready),
		.i_wdata(o_wdata), .i_wstrb(o_wstrb),
		.o_bvalid(i_bvalid), .i_bready(o_bready), .o_bresp(i_bresp)
	);

	// 8 ns clock
	always #4 i_clk = ~i_clk;

	////////////////////////////////////////////////////////////
	// checks and per-entry sequencing
	////////////////////////////////////////////////////////////
	task automatic check(input logic ok, input string what);
		assert (ok) else begin
			$display("Fail at %0t: %s", $time, what);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first error");
		end
	endtask

	// o_stall must hold until the single o_ack
	task automatic wait_core_done(input entry_t e, input int idx);
		logic done;
		done = 1'b0;
		while (!done) begin
			@(posedge i_clk);
			if (o_ack) begin
				done = 1'b1;
				check(!o_stall, $sformatf("entry %0d o_stall high with o_ack", idx));
				check(o_dabt == e.exp_abt,
					$sformatf("entry %0d o_dabt %0b expected %0b", idx, o_dabt, e.exp_abt));
				if (e.op == OP_CORE_RD && !e.exp_abt) begin
					check(o_read_data == e.exp_data[0], $sformatf(
						"entry %0d read 0x%08h expected 0x%08h", idx, o_read_data, e.exp_data[0]));
				end
			end else begin
				check(o_stall, $sformatf("entry %0d o_stall low before o_ack", idx));
				check(!o_dabt, $sformatf("entry %0d o_dabt without o_ack", idx));
			end
		end
	endtask

	// a fill collects its beats until o_stall_cache drops and a write-back just waits for it
	task automatic wait_cache_done(input entry_t e, input int idx);
		int   beats;
		logic done;
		beats = 0;
		done  = 1'b0;
		while (!done) begin
			@(posedge i_clk);
			if (o_cache_rvalid) begin
				check(e.op == OP_LINE_FILL && beats < 4,
					$sformatf("entry %0d unexpected o_cache_rvalid beat %0d", idx, beats));
				check(o_read_data == e.exp_data[beats],
					$sformatf("entry %0d beat %0d 0x%08h expected 0x%08h",
					idx, beats, o_read_data, e.exp_data[beats]));
				beats++;
			end
			done = !o_stall_cache;
		end
		if (e.op == OP_LINE_FILL) begin
			check(beats == 4,
				$sformatf("entry %0d o_stall_cache dropped after %0d beats", idx, beats));
			check(!o_ack, $sformatf("entry %0d o_ack during a line fill", idx));
		end else begin
			check(o_ack, $sformatf("entry %0d write-back ended without o_ack", idx));
			check(o_dabt == e.exp_abt, $sformatf("entry %0d write-back o_dabt %0b", idx, o_dabt));
		end
	endtask

	task automatic run_entry(input entry_t e, input int idx);
		@(negedge i_clk);
		i_address      = e.addr;
		i_write_data   = e.wdata;
		i_byte_enable  = e.be;
		i_exclusive    = e.excl;
		i_write_enable = (e.op == OP_CORE_WR) || (e.op == OP_WRITE_BACK);
		if ((e.op == OP_CORE_RD) || (e.op == OP_CORE_WR)) begin
			i_select = 1'b1;
			wait_core_done(e, idx);
		end else begin
			i_cache_req = 1'b1;
			wait_cache_done(e, idx);
		end
		// drop the request and expect all status low a cycle later
		@(negedge i_clk);
		i_select    = 1'b0;
		i_cache_req = 1'b0;
		@(posedge i_clk);
		check(!o_ack && !o_stall && !o_stall_cache && !o_dabt,
			$sformatf("entry %0d status still active after completion", idx));
	endtask

	////////////////////////////////////////////////////////////
	// AXI attributes
	////////////////////////////////////////////////////////////
	// word-sized beats, single-beat writes, fills as one WRAP burst of a line
	always @(posedge i_clk) begin
		if (i_rstn && o_arvalid) begin
			check(o_arsize == 3'd2, $sformatf("ARSIZE %0d expected 2", o_arsize));
			if (i_cache_req) begin
				check(o_arlen == 8'(`A23_LINE_BEATS - 1) && o_arburst == 2'b10,
					$sformatf("fill ARLEN %0d ARBURST %0d expected WRAP of %0d beats",
					o_arlen, o_arburst, `A23_LINE_BEATS));
			end else begin
				check(o_arlen == 8'd0 && o_arburst == 2'b01,
					$sformatf("core read ARLEN %0d ARBURST %0d expected one INCR beat",
					o_arlen, o_arburst));
			end
		end
		if (i_rstn && o_awvalid) begin
			check(o_awlen == 8'd0 && o_awsize == 3'd2,
				$sformatf("AWLEN %0d AWSIZE %0d expected one word beat", o_awlen, o_awsize));
		end
		if (i_rstn && o_wvalid) begin
			check(o_wlast, "WLAST low on the only beat of a write");
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////
	initial begin
		i_rstn         = 1'b0;
		i_select       = 1'b0;
		i_write_enable = 1'b0;
		i_exclusive    = 1'b0;
		i_cache_req    = 1'b0;
		i_address      = '0;
		i_write_data   = '0;
		i_byte_enable  = '0;
		repeat (5) @(posedge i_clk);
		@(negedge i_clk);
		i_rstn = 1'b1;
		@(posedge i_clk);
		check(!(o_arvalid || o_awvalid || o_wvalid || o_rready || o_bready),
			"AXI valid or ready active right after reset");
		check(!(o_ack || o_dabt || o_cache_rvalid || o_stall || o_stall_cache),
			"core or cache status active right after reset");
		for (int i = 0; i < N_ENTRIES; i++) begin
			run_entry(tbl[i], i);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin
		repeat ((N_ENTRIES * CYCLES_PER_ENTRY) + 10) @(posedge i_clk);
		$display("run timed out: table not finished within %0d cycles",
			N_ENTRIES * CYCLES_PER_ENTRY);
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== verification/a23_axi_slave_model.sv ====
// AXI4 slave model for the a23 bus interface testbench
// word memory, LFSR-driven ready delays, responses chosen by address and lock
`timescale 1ns/100ps
`include "a23_axi_defs.svh"

module a23_axi_slave_model (
	input  logic                       i_clk,
	input  logic                       i_rstn,
	// read address and data
	input  logic                       i_arvalid,
	output logic                       o_arready,
	input  logic [`A23_ADDR_W-1:0]     i_araddr,
	input  logic [1:0]                 i_arburst,
	input  logic [7:0]                 i_arlen,
	input  logic                       i_arlock,
	output logic                       o_rvalid,
	input  logic                       i_rready,
	output logic [`A23_DATA_W-1:0]     o_rdata,
	output a23_axi_pkg::axi_resp_t     o_rresp,
	output logic                       o_rlast,
	// write address, data and response
	input  logic                       i_awvalid,
	output logic                       o_awready,
	input  logic [`A23_ADDR_W-1:0]     i_awaddr,
	input  logic                       i_awlock,
	input  logic                       i_wvalid,
	output logic                       o_wready,
	input  logic [`A23_DATA_W-1:0]     i_wdata,
	input  logic [`A23_STRB_W-1:0]     i_wstrb,
	output logic                       o_bvalid,
	input  logic                       i_bready,
	output a23_axi_pkg::axi_resp_t     o_bresp
);
	import a23_axi_pkg::*;

	// only written words live here, keyed by word address
	logic [31:0] mem [logic [29:0]];
	// fibonacci LFSR, taps 16 14 13 11
	logic [15:0] lfsr = 16'd7746;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////
	// unwritten words read back as their own word address inverted
	function automatic logic [31:0] mem_word(input logic [29:0] wa);
		if (mem.exists(wa)) begin
			return mem[wa];
		end
		return ~{2'b00, wa};
	endfunction

	// one LFSR step per bit
	function logic rand_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	// 0 to 3 wait cycles
	function logic [1:0] wait_cycles();
		logic [1:0] n;
		n[1] = rand_bit();
		n[0] = rand_bit();
		return n;
	endfunction

	// error region first, then exclusive, else plain okay
	function automatic axi_resp_t resp_for(input logic [31:0] addr, input logic lock);
		if (addr[31]) begin
			return RESP_SLVERR;
		end
		return lock ? RESP_EXOKAY : RESP_OKAY;
	endfunction

	// starts and ends on a falling edge
	task automatic wait_random();
		logic [1:0] n;
		n = wait_cycles();
		repeat (n) @(negedge i_clk);
	endtask

	////////////////////////////////////////////////////////////
	// AR and R
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] addr;
		logic [7:0]  len;
		logic        wrap;
		logic        lock;
		logic [29:0] wa;
		o_arready = 1'b0;
		o_rvalid  = 1'b0;
		o_rdata   = '0;
		o_rresp   = RESP_OKAY;
		o_rlast   = 1'b0;
		forever begin
			@(posedge i_clk);
			if (i_rstn && i_arvalid) begin
				addr = i_araddr;
				len  = i_arlen;
				wrap = (i_arburst == 2'b10);
				lock = i_arlock;
				@(negedge i_clk);
				wait_random();
				o_arready = 1'b1;
				@(posedge i_clk);
				@(negedge i_clk);
				o_arready = 1'b0;
				for (int i = 0; i <= int'(len); i++) begin
					wait_random();
					// wrap stays inside the 16-byte line
					if (wrap) begin
						wa = {addr[31:4], addr[3:2] + 2'(i)};
					end else begin
						wa = addr[31:2] + 30'(i);
					end
					o_rvalid = 1'b1;
					o_rdata  = mem_word(wa);
					o_rresp  = resp_for(addr, lock);
					o_rlast  = (i == int'(len));
					@(posedge i_clk);
					while (!i_rready) @(posedge i_clk);
					@(negedge i_clk);
					o_rvalid = 1'b0;
					o_rlast  = 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// AW, W and B
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] addr;
		logic        lock;
		logic [31:0] word;
		o_awready = 1'b0;
		o_wready  = 1'b0;
		o_bvalid  = 1'b0;
		o_bresp   = RESP_OKAY;
		forever begin
			@(posedge i_clk);
			if (i_rstn && i_awvalid) begin
				addr = i_awaddr;
				lock = i_awlock;
				@(negedge i_clk);
				wait_random();
				o_awready = 1'b1;
				@(posedge i_clk);
				@(negedge i_clk);
				o_awready = 1'b0;
				wait_random();
				o_wready = 1'b1;
				@(posedge i_clk);
				while (!i_wvalid) @(posedge i_clk);
				// strobed byte merge, error region never written
				word = mem_word(addr[31:2]);
				for (int b = 0; b < `A23_STRB_W; b++) begin
					if (i_wstrb[b]) begin
						word[8*b +: 8] = i_wdata[8*b +: 8];
					end
				end
				if (!addr[31]) begin
					mem[addr[31:2]] = word;
				end
				@(negedge i_clk);
				o_wready = 1'b0;
				wait_random();
				o_bvalid = 1'b1;
				o_bresp  = resp_for(addr, lock);
				@(posedge i_clk);
				while (!i_bready) @(posedge i_clk);
				@(negedge i_clk);
				o_bvalid = 1'b0;
			end
		end
	end

endmodule

// ==== logic/a23_axi_if.sv ====
// a23 AXI bus interface top level
// read engine and write engine side by side, merged into core and cache status
`timescale 1ns/100ps
`include "a23_axi_defs.svh"

module a23_axi_if (
	input  logic                       i_clk,
	input  logic                       i_rstn,
	// core requests
	input  logic                       i_select,
	input  logic                       i_write_enable,
	input  logic                       i_exclusive,
	input  logic [`A23_ADDR_W-1:0]     i_address,
	input  logic [`A23_DATA_W-1:0]     i_write_data,
	input  logic [`A23_STRB_W-1:0]     i_byte_enable,
	output logic                       o_ack,
	output logic                       o_stall,
	output logic                       o_dabt,
	output logic [`A23_DATA_W-1:0]     o_read_data,
	// cache requests
	input  logic                       i_cache_req,
	output logic                       o_stall_cache,
	output logic                       o_cache_rvalid,
	// AXI read address and data
	output logic                       o_arvalid,
	input  logic                       i_arready,
	output logic [`A23_ADDR_W-1:0]     o_araddr,
	output logic [7:0]                 o_arlen,
	output logic [1:0]                 o_arburst,
	output logic [2:0]                 o_arsize,
	output logic                       o_arlock,
	input  logic                       i_rvalid,
	output logic                       o_rready,
	input  logic [`A23_DATA_W-1:0]     i_rdata,
	input  a23_axi_pkg::axi_resp_t     i_rresp,
	input  logic                       i_rlast,
	// AXI write address, data and response
	output logic                       o_awvalid,
	input  logic                       i_awready,
	output logic [`A23_ADDR_W-1:0]     o_awaddr,
	output logic [7:0]                 o_awlen,
	output logic [2:0]                 o_awsize,
	output logic                       o_awlock,
	output logic                       o_wvalid,
	input  logic                       i_wready,
	output logic [`A23_DATA_W-1:0]     o_wdata,
	output logic [`A23_STRB_W-1:0]     o_wstrb,
	output logic                       o_wlast,
	input  logic                       i_bvalid,
	output logic                       o_bready,
	input  a23_axi_pkg::axi_resp_t     i_bresp
);
	import a23_axi_pkg::*;

	// engine events into the merger
	logic                       core_rd_done;
	logic                       line_rd_beat;
	logic                       line_busy;
	logic                       core_wr_done;
	logic                       line_wr_done;
	axi_resp_t                  rd_resp;
	axi_resp_t                  wr_resp;
	logic [`A23_DATA_W-1:0]     rd_data;

	a23_axi_read_engine u_read_engine (
		.i_clk, .i_rstn,
		.i_select, .i_cache_req, .i_write_enable, .i_exclusive, .i_address,
		.i_arready, .i_rvalid, .i_rdata, .i_rresp, .i_rlast,
		.o_arvalid, .o_araddr, .o_arlen, .o_arburst, .o_arsize, .o_arlock,
		.o_rready,
		.o_rdata        (rd_data),
		.o_core_rd_done (core_rd_done),
		.o_line_rd_beat (line_rd_beat),
		.o_line_busy    (line_busy),
		.o_rd_resp      (rd_resp)
	);

	a23_axi_write_engine u_write_engine (
		.i_clk, .i_rstn,
		.i_select, .i_cache_req, .i_write_enable, .i_exclusive, .i_address,
		.i_write_data, .i_byte_enable,
		.i_awready, .i_wready, .i_bvalid, .i_bresp,
		.o_awvalid, .o_awaddr, .o_awlen, .o_awsize, .o_awlock,
		.o_wvalid, .o_wdata, .o_wstrb, .o_wlast, .o_bready,
		.o_core_wr_done (core_wr_done),
		.o_line_wr_done (line_wr_done),
		.o_wr_resp      (wr_resp)
	);

	a23_axi_resp_merge u_resp_merge (
		.i_select, .i_cache_req, .i_write_enable, .i_exclusive,
		.i_core_rd_done (core_rd_done),
		.i_line_rd_beat (line_rd_beat),
		.i_line_busy    (line_busy),
		.i_core_wr_done (core_wr_done),
		.i_line_wr_done (line_wr_done),
		.i_rd_resp      (rd_resp),
		.i_wr_resp      (wr_resp),
		.i_rdata        (rd_data),
		.o_ack, .o_stall, .o_stall_cache, .o_dabt,
		.o_read_data, .o_cache_rvalid
	);

endmodule

// ==== logic/a23_axi_resp_merge.sv ====
// a23 AXI response merger
// turns engine completions into core and cache acknowledge, stall and abort
`timescale 1ns/100ps
`include "a23_axi_defs.svh"

module a23_axi_resp_merge (
	input  logic                       i_select,
	input  logic                       i_cache_req,
	input  logic                       i_write_enable,
	input  logic                       i_exclusive,
	input  logic                       i_core_rd_done,
	input  logic                       i_line_rd_beat,
	input  logic                       i_line_busy,
	input  logic                       i_core_wr_done,
	input  logic                       i_line_wr_done,
	input  a23_axi_pkg::axi_resp_t     i_rd_resp,
	input  a23_axi_pkg::axi_resp_t     i_wr_resp,
	input  logic [`A23_DATA_W-1:0]     i_rdata,
	output logic                       o_ack,
	output logic                       o_stall,
	output logic                       o_stall_cache,
	output logic                       o_dabt,
	output logic [`A23_DATA_W-1:0]     o_read_data,
	output logic                       o_cache_rvalid
);
	import a23_axi_pkg::*;

	logic       core_rd_req;
	logic       core_wr_req;
	logic       line_wr_req;
	logic       wr_done;
	axi_resp_t  exp_resp;

	// pending requests by direction
	assign core_rd_req = i_select && !i_write_enable;
	assign core_wr_req = i_select && i_write_enable;
	assign line_wr_req = i_cache_req && i_write_enable;

	assign wr_done = i_core_wr_done || i_line_wr_done;

	////////////////////////////////////////////////////////////
	// acknowledge and stall
	////////////////////////////////////////////////////////////
	// one pulse per completed core access or write-back
	assign o_ack = i_core_rd_done || wr_done;

	// core waits until its own access completes
	assign o_stall = (core_rd_req && !i_core_rd_done) ||
		(core_wr_req && !i_core_wr_done);

	// line fill stall comes from the read engine
	// write-back stalls until its B beat
	assign o_stall_cache = i_line_busy || (line_wr_req && !i_line_wr_done);

	////////////////////////////////////////////////////////////
	// data abort
	////////////////////////////////////////////////////////////
	// exclusive accesses must see EXOKAY, all others OKAY
	assign exp_resp = i_exclusive ? RESP_EXOKAY : RESP_OKAY;

	assign o_dabt = (i_core_rd_done && (i_rd_resp != exp_resp)) ||
		(wr_done && (i_wr_resp != exp_resp));

	// read data goes to core and cache alike
	assign o_read_data    = i_rdata;
	assign o_cache_rvalid = i_line_rd_beat;

endmodule

// ==== logic/a23_axi_write_engine.sv ====
// a23 AXI write engine
// single-beat AW, W and B sequence for core stores and cache write-backs
`timescale 1ns/100ps
`include "a23_axi_defs.svh"

module a23_axi_write_engine (
	input  logic                       i_clk,
	input  logic                       i_rstn,
	input  logic                       i_select,
	input  logic                       i_cache_req,
	input  logic                       i_write_enable,
	input  logic                       i_exclusive,
	input  logic [`A23_ADDR_W-1:0]     i_address,
	input  logic [`A23_DATA_W-1:0]     i_write_data,
	input  logic [`A23_STRB_W-1:0]     i_byte_enable,
	input  logic                       i_awready,
	input  logic                       i_wready,
	input  logic                       i_bvalid,
	input  a23_axi_pkg::axi_resp_t     i_bresp,
	output logic                       o_awvalid,
	output logic [`A23_ADDR_W-1:0]     o_awaddr,
	output logic [7:0]                 o_awlen,
	output logic [2:0]                 o_awsize,
	output logic                       o_awlock,
	output logic                       o_wvalid,
	output logic [`A23_DATA_W-1:0]     o_wdata,
	output logic [`A23_STRB_W-1:0]     o_wstrb,
	output logic                       o_wlast,
	output logic                       o_bready,
	output logic                       o_core_wr_done,
	output logic                       o_line_wr_done,
	output a23_axi_pkg::axi_resp_t     o_wr_resp
);
	import a23_axi_pkg::*;

	wr_state_t  wr_state;
	wr_state_t  wr_next;
	logic       core_wr_req;
	logic       line_wr_req;

	// this engine only serves writes
	assign core_wr_req = i_select && i_write_enable;
	assign line_wr_req = i_cache_req && i_write_enable;

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			wr_state <= WR_IDLE;
		end else begin
			wr_state <= wr_next;
		end
	end

	always_comb begin
		wr_next = wr_state;
		case (wr_state)
			WR_IDLE: begin
				// write-back goes ahead of a core store
				if (line_wr_req) begin
					wr_next = WR_LINE_ADDR;
				end else if (core_wr_req) begin
					wr_next = WR_CORE_ADDR;
				end
			end
			// core store
			WR_CORE_ADDR: if (i_awready) wr_next = WR_CORE_DATA;
			WR_CORE_DATA: if (i_wready)  wr_next = WR_CORE_RESP;
			WR_CORE_RESP: if (i_bvalid)  wr_next = WR_IDLE;
			// cache write-back
			WR_LINE_ADDR: if (i_awready) wr_next = WR_LINE_DATA;
			WR_LINE_DATA: if (i_wready)  wr_next = WR_LINE_RESP;
			WR_LINE_RESP: if (i_bvalid)  wr_next = WR_IDLE;
			default:      wr_next = WR_IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// AW, W and B channel
	////////////////////////////////////////////////////////////
	assign o_awvalid = (wr_state == WR_CORE_ADDR) || (wr_state == WR_LINE_ADDR);
	assign o_awaddr  = {i_address[`A23_ADDR_W-1:2], 2'b00};
	// one beat of one word
	assign o_awlen   = 8'd0;
	assign o_awsize  = 3'd2;
	assign o_awlock  = o_awvalid && i_exclusive;

	assign o_wvalid = (wr_state == WR_CORE_DATA) || (wr_state == WR_LINE_DATA);
	assign o_wdata  = i_write_data;
	// strobes select the bytes of a partial store
	assign o_wstrb  = i_byte_enable;
	assign o_wlast  = o_wvalid;

	assign o_bready = (wr_state == WR_CORE_RESP) || (wr_state == WR_LINE_RESP);

	// bvalid alone completes a write since bready is high in both response states
	assign o_core_wr_done = (wr_state == WR_CORE_RESP) && i_bvalid;
	assign o_line_wr_done = (wr_state == WR_LINE_RESP) && i_bvalid;
	assign o_wr_resp      = i_bresp;

	// write payload holds while W waits for the slave
	a_w_stable: assert property (@(posedge i_clk) disable iff (!i_rstn)
		o_wvalid && !i_wready |=> $stable(o_wdata) && $stable(o_wstrb));

endmodule

// ==== logic/a23_axi_read_engine.sv ====
// a23 AXI read engine
// drives AR and R for core single reads and 4-beat wrapping cache line fills
`timescale 1ns/100ps
`include "a23_axi_defs.svh"

module a23_axi_read_engine (
	input  logic                       i_clk,
	input  logic                       i_rstn,
	input  logic                       i_select,
	input  logic                       i_cache_req,
	input  logic                       i_write_enable,
	input  logic                       i_exclusive,
	input  logic [`A23_ADDR_W-1:0]     i_address,
	input  logic                       i_arready,
	input  logic                       i_rvalid,
	input  logic [`A23_DATA_W-1:0]     i_rdata,
	input  a23_axi_pkg::axi_resp_t     i_rresp,
	input  logic                       i_rlast,
	output logic                       o_arvalid,
	output logic [`A23_ADDR_W-1:0]     o_araddr,
	output logic [7:0]                 o_arlen,
	output logic [1:0]                 o_arburst,
	output logic [2:0]                 o_arsize,
	output logic                       o_arlock,
	output logic                       o_rready,
	output logic [`A23_DATA_W-1:0]     o_rdata,
	output logic                       o_core_rd_done,
	output logic                       o_line_rd_beat,
	output logic                       o_line_busy,
	output a23_axi_pkg::axi_resp_t     o_rd_resp
);
	import a23_axi_pkg::*;

	// burst length field for a line fill
	localparam logic [7:0] LINE_LEN = 8'(`A23_LINE_BEATS - 1);
	localparam int         CNT_W    = $clog2(`A23_LINE_BEATS);

	rd_state_t            rd_state;
	rd_state_t            rd_next;
	logic                 core_rd_req;
	logic                 line_rd_req;
	logic                 r_last_hs;
	logic [CNT_W-1:0]     beat_cnt;

	// this engine only serves reads
	assign core_rd_req = i_select && !i_write_enable;
	assign line_rd_req = i_cache_req && !i_write_enable;

	// rready is high in both data states, so a valid beat is accepted
	assign r_last_hs = i_rvalid && i_rlast;

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			rd_state <= RD_IDLE;
		end else begin
			rd_state <= rd_next;
		end
	end

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			RD_IDLE: begin
				// cache wins over the core
				if (line_rd_req) begin
					rd_next = RD_LINE_ADDR;
				end else if (core_rd_req) begin
					rd_next = RD_CORE_ADDR;
				end
			end
			RD_CORE_ADDR: if (i_arready) rd_next = RD_CORE_DATA;
			RD_CORE_DATA: if (r_last_hs) rd_next = RD_IDLE;
			RD_LINE_ADDR: if (i_arready) rd_next = RD_LINE_DATA;
			RD_LINE_DATA: if (r_last_hs) rd_next = RD_IDLE;
			default:      rd_next = RD_IDLE;
		endcase
	end

	// counts accepted beats of a line fill
	always_ff @(posedge i_clk) begin
		if (!i_rstn || rd_state != RD_LINE_DATA) begin
			beat_cnt <= '0;
		end else if (i_rvalid) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// AR and R channel
	////////////////////////////////////////////////////////////
	assign o_arvalid = (rd_state == RD_CORE_ADDR) || (rd_state == RD_LINE_ADDR);
	// word aligned, as a wrap burst needs
	assign o_araddr  = {i_address[`A23_ADDR_W-1:2], 2'b00};
	assign o_arlen   = (rd_state == RD_LINE_ADDR) ? LINE_LEN : 8'd0;
	// WRAP for line fills, INCR for the core
	assign o_arburst = (rd_state == RD_LINE_ADDR) ? 2'b10 : 2'b01;
	assign o_arsize  = 3'd2;
	assign o_arlock  = o_arvalid && i_exclusive;
	assign o_rready  = (rd_state == RD_CORE_DATA) || (rd_state == RD_LINE_DATA);

	// beat payload straight through
	assign o_rdata   = i_rdata;
	assign o_rd_resp = i_rresp;

	////////////////////////////////////////////////////////////
	// events for the merger
	////////////////////////////////////////////////////////////
	assign o_core_rd_done = (rd_state == RD_CORE_DATA) && r_last_hs;
	assign o_line_rd_beat = (rd_state == RD_LINE_DATA) && i_rvalid;

	// fill pending from the request cycle until its last beat is taken
	assign o_line_busy = ((rd_state == RD_IDLE) && line_rd_req) ||
		(rd_state == RD_LINE_ADDR) ||
		((rd_state == RD_LINE_DATA) && !r_last_hs);

	// core keeps the address steady while AR is stalled
	a_araddr_stable: assert property (@(posedge i_clk) disable iff (!i_rstn)
		o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

	// slave ends a line fill on exactly the fourth beat
	a_line_rlast: assert property (@(posedge i_clk) disable iff (!i_rstn)
		(rd_state == RD_LINE_DATA) && i_rvalid |->
		(i_rlast == (beat_cnt == LINE_LEN[CNT_W-1:0])));

endmodule

// ==== logic/a23_axi_pkg.sv ====
// a23 AXI bus interface types
// engine state encodings and the AXI response code
package a23_axi_pkg;

	// read engine states
	// core reads use the CORE pair, cache line fills the LINE pair
	typedef enum logic [2:0] {
		RD_IDLE,
		RD_CORE_ADDR,
		RD_CORE_DATA,
		RD_LINE_ADDR,
		RD_LINE_DATA
	} rd_state_t;

	// write engine states
	// address, data and response phases in order
	typedef enum logic [2:0] {
		WR_IDLE,
		WR_CORE_ADDR,
		WR_CORE_DATA,
		WR_CORE_RESP,
		WR_LINE_ADDR,
		WR_LINE_DATA,
		WR_LINE_RESP
	} wr_state_t;

	// RRESP and BRESP encoding
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_t;

endpackage

// ==== logic/a23_axi_defs.svh ====
// a23 AXI bus interface
// bus widths and cache line length shared across the design
`ifndef A23_AXI_DEFS_SVH
`define A23_AXI_DEFS_SVH

// byte address width of the AXI bus
`define A23_ADDR_W      32

// read and write data width
`define A23_DATA_W      32

// one strobe bit per data byte
`define A23_STRB_W      4

// words per cache line, one burst beat each
`define A23_LINE_BEATS  4

`endif
